//--- bench/frontend_tb.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module frontend_tb;
    import fe_pkg::*;

    localparam int NUM_OUTPUTS = 3000;
    localparam int K_PLAIN     = 0;
    localparam int K_B         = 1;
    localparam int K_BL        = 2;
    localparam int K_RET       = 3;
    localparam int K_JIRL      = 4;
    localparam int K_COND      = 5;

    logic           clk;
    logic           rst_n;
    logic           icache_req_valid;
    virt_t          icache_req_addr;
    logic           icache_req_ready;
    inst_u          icache_rsp_data;
    logic           icache_rsp_valid;
    logic           icache_rsp_ready;
    fetch2_decode_t dec;
    logic           dec_stall;
    logic           be_redirect;
    virt_t          be_redirect_pc;

    logic [31:0]    prog_mem [256];
    virt_t          req_queue [$];
    virt_t          ras_model [$];
    int             wait_cnt;
    logic           rsp_done;
    logic           redirect_pending;
    virt_t          redirect_target;
    virt_t          expected_pc;
    logic           held_valid;
    fetch2_decode_t held_dec;
    int             taken;
    int             redirects;
    int             accepted;

    frontend_top frontend_top_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .icache_req_valid_o (icache_req_valid),
        .icache_req_addr_o  (icache_req_addr),
        .icache_req_ready_i (icache_req_ready),
        .icache_rsp_data_i  (icache_rsp_data),
        .icache_rsp_valid_i (icache_rsp_valid),
        .icache_rsp_ready_o (icache_rsp_ready),
        .dec_o              (dec),
        .dec_stall_i        (dec_stall),
        .be_redirect_i      (be_redirect),
        .be_redirect_pc_i   (be_redirect_pc)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        abort_run($sformatf("Fail %s: expected %0h actual %0h", name, exp, act));
    endtask

    // the word seen at a pc depends on the whole address, so btb tags can alias
    function automatic int unsigned mem_index(virt_t a);
        return a[9:2] ^ a[17:10] ^ a[25:18] ^ {2'b00, a[31:26]};
    endfunction

    function automatic int word_kind(logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op == `FE_OP_B) return K_B;
        if (op == `FE_OP_BL) return K_BL;
        if (op == `FE_OP_JIRL) begin
            return (w[25:0] == {16'd0, 5'd1, 5'd0}) ? K_RET : K_JIRL;
        end
        if (op >= `FE_OP_BEQ && op <= `FE_OP_BGEU) return K_COND;
        return K_PLAIN;
    endfunction

    function automatic virt_t window_addr();
        return `FE_RESET_PC + (($urandom % 4096) << 2);
    endfunction

    function automatic logic [31:0] random_word();
        int          pick;
        int          off;
        logic [25:0] o26;
        logic [5:0]  op;
        logic [31:0] w;
        pick = $urandom % 100;
        off  = int'($urandom % 1024) - 512;   // jump distance in words
        o26  = off[25:0];
        if (pick < 40) begin
            op = $urandom % 64;
            while (op >= `FE_OP_JIRL && op <= `FE_OP_BGEU) op = $urandom % 64;
            w = {op, 26'($urandom)};
        end else if (pick < 52) begin
            w = {`FE_OP_B, o26[15:0], o26[25:16]};
        end else if (pick < 62) begin
            w = {`FE_OP_BL, o26[15:0], o26[25:16]};
        end else if (pick < 72) begin
            w = {`FE_OP_JIRL, 16'd0, 5'd1, 5'd0};
        end else if (pick < 78) begin
            w = {`FE_OP_JIRL, 26'($urandom)};
            if (w[25:0] == {16'd0, 5'd1, 5'd0}) w[0] = 1'b1;
        end else begin
            op = `FE_OP_BEQ + 6'($urandom % 6);
            w  = {op, o26[15:0], 10'($urandom)};
        end
        return w;
    endfunction

    task automatic take_output();
        logic [31:0] w;
        virt_t       succ;
        virt_t       tgt;
        w = prog_mem[mem_index(expected_pc)];
        assert (dec.pc == expected_pc) else report_mismatch("program flow pc", expected_pc, dec.pc);
        assert (dec.inst == w) else report_mismatch("instruction word", w, dec.inst);
        succ = dec.pc + 32'd4;
        case (word_kind(w))
            K_B, K_BL: begin
                tgt  = {{6{w[9]}}, w[9:0], w[25:10]};
                succ = dec.pc + (tgt << 2);
                assert (dec.next.pc == succ) else report_mismatch("direct jump", succ, dec.next.pc);
                assert (dec.next.is_predict == 1'b0)
                    else report_mismatch("direct jump predict", 0, dec.next.is_predict);
                if (word_kind(w) == K_BL) begin
                    ras_model.push_back(dec.pc + 32'd4);
                    if (ras_model.size() > `FE_RAS_DEPTH) void'(ras_model.pop_front());
                end
            end
            K_COND: begin
                tgt = {{16{w[25]}}, w[25:10]};
                if ($urandom % 2) succ = dec.pc + (tgt << 2);
            end
            K_RET: begin
                if (ras_model.size() > 0) begin
                    succ = ras_model.pop_back();
                    assert (dec.next.pc == succ) else report_mismatch("return", succ, dec.next.pc);
                    assert (dec.next.is_predict == 1'b1)
                        else report_mismatch("return predict", 1, dec.next.is_predict);
                end else begin
                    succ = window_addr();
                end
            end
            K_JIRL: succ = window_addr();
            default: begin
                assert (dec.next.pc == succ) else report_mismatch("plain word", succ, dec.next.pc);
            end
        endcase
        if (dec.next.pc != succ) begin
            redirect_pending = 1'b1;
            redirect_target  = succ;
            redirects++;
        end
        expected_pc = succ;
        taken++;
    endtask

    initial begin
        void'($urandom(32'hc4d7));
        for (int i = 0; i < 256; i++) prog_mem[i] = random_word();
        clk              = 1'b0;
        rst_n            = 1'b0;
        icache_req_ready = 1'b0;
        icache_rsp_data  = '0;
        icache_rsp_valid = 1'b0;
        dec_stall        = 1'b0;
        be_redirect      = 1'b0;
        be_redirect_pc   = '0;
        wait_cnt         = 0;
        rsp_done         = 1'b0;
        redirect_pending = 1'b0;
        expected_pc      = `FE_RESET_PC;
        held_valid       = 1'b0;
        taken            = 0;
        redirects        = 0;
        accepted         = 0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            if (c == 3) rst_n = 1'b1;   // last pass checks the cycle after release
            #1;
            assert (!dec.valid && !icache_req_valid)
                else abort_run("outputs active during or right after reset");
        end
        while (taken < NUM_OUTPUTS) begin
            @(negedge clk);
            be_redirect      = redirect_pending;
            be_redirect_pc   = redirect_target;
            redirect_pending = 1'b0;
            dec_stall        = ($urandom % 5 == 0);
            icache_req_ready = ($urandom % 10 < 7);
            if (rsp_done) begin
                icache_rsp_valid = 1'b0;
                rsp_done         = 1'b0;
            end
            if (!icache_rsp_valid && req_queue.size() > 0) begin
                if (wait_cnt == 0) begin
                    icache_rsp_valid = 1'b1;
                    icache_rsp_data  = prog_mem[mem_index(req_queue[0])];
                end else begin
                    wait_cnt--;
                end
            end
            #1;   // inputs settled, these are the values the next rising edge sees
            if (held_valid && !be_redirect) begin
                assert (dec === held_dec) else report_mismatch("stall hold", held_dec, dec);
            end
            held_valid = dec.valid && dec_stall;
            held_dec   = dec;
            if (dec.valid && !dec_stall) begin
                assert (icache_rsp_valid && icache_rsp_ready && dec.pc == req_queue[0])
                    else abort_run("decode output taken without its own cache response");
            end
            if (icache_rsp_valid && icache_rsp_ready) begin
                void'(req_queue.pop_front());
                rsp_done = 1'b1;
            end
            if (icache_req_valid && icache_req_ready) begin
                assert (req_queue.size() == 0)
                    else abort_run("cache request accepted while another is outstanding");
                wait_cnt = $urandom % 3;
                req_queue.push_back(icache_req_addr);
                accepted++;
            end
            if (dec.valid && !dec_stall) take_output();
        end
        assert (redirects > 0) else abort_run("no backend redirect was exercised");
        $display("outputs %0d redirects %0d requests %0d", taken, redirects, accepted);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (NUM_OUTPUTS * 12) @(posedge clk);
        abort_run("watchdog expired before all decode outputs were taken");
    end

endmodule

//--- frontend_top.f
+incdir+hw
hw/fe_pkg.sv
hw/branch_target_buffer.sv
hw/return_addr_stack.sv
hw/fetch_pc_gen.sv
hw/fetch_predecode.sv
hw/frontend_top.sv
bench/frontend_tb.sv

//--- hw/branch_target_buffer.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module branch_target_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  fe_pkg::virt_t       lookup_pc_i,
    output logic                hit_o,
    output fe_pkg::virt_t       target_o,
    input  fe_pkg::btb_update_t update_i
);
    import fe_pkg::*;

    localparam int ENTRIES = 1 << `FE_BTB_IDX_W;
    localparam int IDX_LO  = 2;
    localparam int IDX_HI  = IDX_LO + `FE_BTB_IDX_W - 1;
    localparam int TAG_LO  = IDX_HI + 1;
    localparam int TAG_HI  = TAG_LO + `FE_BTB_TAG_W - 1;

    logic [ENTRIES-1:0]       valid_q;
    logic [`FE_BTB_TAG_W-1:0] tag_q [ENTRIES];
    virt_t                    target_q [ENTRIES];

    logic [`FE_BTB_IDX_W-1:0] rd_idx;
    logic [`FE_BTB_TAG_W-1:0] rd_tag;
    logic [`FE_BTB_IDX_W-1:0] wr_idx;
    logic [`FE_BTB_TAG_W-1:0] wr_tag;

    assign rd_idx = lookup_pc_i[IDX_HI:IDX_LO];
    assign rd_tag = lookup_pc_i[TAG_HI:TAG_LO];
    assign wr_idx = update_i.pc[IDX_HI:IDX_LO];
    assign wr_tag = update_i.pc[TAG_HI:TAG_LO];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[wr_idx] <= ~update_i.invalidate;
        end
    end

    always_ff @(posedge clk) begin
        if (update_i.valid && !update_i.invalidate) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= update_i.target;
        end
    end

    // fetch2 only trains from aligned instructions with word-aligned jump targets
    assert property (@(posedge clk) disable iff (!rst_n)
        update_i.valid |-> (update_i.pc[1:0] == 2'b00)
                           && (update_i.invalidate || update_i.target[1:0] == 2'b00));

endmodule

//--- hw/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

`define FE_RESET_PC     32'h1c000000

// btb geometry, tag kept short so unrelated pcs can alias
`define FE_BTB_IDX_W    4
`define FE_BTB_TAG_W    6

`define FE_RAS_DEPTH    4

`define FE_OP_JIRL      6'b010011
`define FE_OP_B         6'b010100
`define FE_OP_BL        6'b010101
`define FE_OP_BEQ       6'b010110
`define FE_OP_BNE       6'b010111
`define FE_OP_BLT       6'b011000
`define FE_OP_BGE       6'b011001
`define FE_OP_BLTU      6'b011010
`define FE_OP_BGEU      6'b011011

`endif

//--- hw/fe_pkg.sv
package fe_pkg;

    typedef logic [31:0] virt_t;

    // b and bl carry a 26-bit word offset split across the word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } offs_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] imm16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } reg_fmt_t;

    typedef union packed {
        offs_fmt_t offs_fmt;
        reg_fmt_t  reg_fmt;
    } inst_u;

    typedef struct packed {
        virt_t pc;
        logic  is_predict;   // successor came from a predictor, not from predecode
    } next_pc_t;

    typedef struct packed {
        logic     valid;
        virt_t    pc;
        next_pc_t next;
        logic     icache_req;
    } fetch1_fetch2_t;

    typedef struct packed {
        logic     valid;
        virt_t    pc;
        inst_u    inst;
        next_pc_t next;
    } fetch2_decode_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
        logic  is_predict;
    } pc_redirect_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
        virt_t target;
        logic  invalidate;   // clear the entry instead of training it
    } btb_update_t;

endpackage

//--- hw/fetch_pc_gen.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   be_redirect_i,
    input  fe_pkg::virt_t          be_redirect_pc_i,
    input  fe_pkg::pc_redirect_t   fix_i,
    input  logic                   f2_busy_i,
    input  logic                   btb_hit_i,
    input  fe_pkg::virt_t          btb_target_i,
    output fe_pkg::virt_t          lookup_pc_o,
    output logic                   icache_req_valid_o,
    output fe_pkg::virt_t          icache_req_addr_o,
    input  logic                   icache_req_ready_i,
    output fe_pkg::fetch1_fetch2_t pass_o,
    output logic                   pass_valid_o
);
    import fe_pkg::*;

    virt_t pc_q;
    logic  req_valid_q;
    logic  redirect;
    logic  accept;
    virt_t pred_pc;

    assign redirect = be_redirect_i | fix_i.valid;

    assign lookup_pc_o = pc_q;
    assign pred_pc     = btb_hit_i ? btb_target_i : pc_q + 32'd4;

    // a redirect withdraws the request so the cache never takes a wrong-path fetch
    assign icache_req_valid_o = req_valid_q & ~redirect;
    assign icache_req_addr_o  = pc_q;
    assign accept             = icache_req_valid_o & icache_req_ready_i;

    always_comb begin
        pass_o.valid           = accept;
        pass_o.pc              = pc_q;
        pass_o.next.pc         = pred_pc;
        pass_o.next.is_predict = btb_hit_i;
        pass_o.icache_req      = 1'b1;   // every pass here carries a cache access
    end
    assign pass_valid_o = accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q        <= `FE_RESET_PC;
            req_valid_q <= 1'b0;
        end else if (be_redirect_i) begin
            pc_q        <= be_redirect_pc_i;
            req_valid_q <= ~f2_busy_i;   // waits out a stale response still in flight
        end else if (fix_i.valid) begin
            pc_q        <= fix_i.pc;
            req_valid_q <= ~f2_busy_i;
        end else if (accept) begin
            pc_q        <= pred_pc;
            req_valid_q <= 1'b0;
        end else if (!f2_busy_i) begin
            req_valid_q <= 1'b1;
        end
    end

    // fetch2 must not turn busy under a pending request unless it also redirects us
    assert property (@(posedge clk) disable iff (!rst_n)
        icache_req_valid_o && !icache_req_ready_i |=>
            $stable(icache_req_addr_o) && (icache_req_valid_o || be_redirect_i || fix_i.valid));

endmodule

//--- hw/fetch_predecode.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module fetch_predecode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  logic                   dec_stall_i,
    input  fe_pkg::fetch1_fetch2_t pass_i,
    input  logic                   pass_valid_i,
    output logic                   busy_o,
    input  fe_pkg::inst_u          icache_rsp_data_i,
    input  logic                   icache_rsp_valid_i,
    output logic                   icache_rsp_ready_o,
    output fe_pkg::fetch2_decode_t dec_o,
    output fe_pkg::pc_redirect_t   fix_o,
    output fe_pkg::btb_update_t    btb_update_o,
    output logic                   ras_push_o,
    output fe_pkg::virt_t          ras_push_addr_o,
    output logic                   ras_pop_o,
    input  fe_pkg::virt_t          ras_top_i,
    input  logic                   ras_top_valid_i
);
    import fe_pkg::*;

    fetch1_fetch2_t pass_r;
    logic           discard_q;

    logic     rsp_hs;
    logic     rsp_wait;
    logic     fire;
    inst_u    inst;
    logic     inst_b;
    logic     inst_bl;
    logic     inst_jirl;
    logic     inst_cond;
    logic     is_br;
    logic     is_return;
    logic     bp_error;
    virt_t    pc_plus4;
    virt_t    jump_to;
    next_pc_t corr;

    assign inst     = icache_rsp_data_i;
    assign rsp_hs   = icache_rsp_valid_i & icache_rsp_ready_o;
    assign rsp_wait = pass_r.icache_req & ~icache_rsp_valid_i;
    assign fire     = dec_o.valid & ~dec_stall_i;

    // stale responses drain even while decode is stalled
    assign icache_rsp_ready_o = ~dec_stall_i | discard_q;
    assign busy_o             = discard_q | dec_stall_i | (pass_r.valid & ~fire);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_r.valid      <= 1'b0;
            pass_r.icache_req <= 1'b0;
            discard_q         <= 1'b0;
        end else if (flush_i) begin
            pass_r.valid      <= 1'b0;
            pass_r.icache_req <= 1'b0;
            discard_q <= (discard_q | (pass_r.valid & pass_r.icache_req)) & ~rsp_hs;
        end else begin
            if (discard_q && rsp_hs) begin
                discard_q <= 1'b0;
            end
            if (pass_valid_i) begin
                pass_r <= pass_i;
            end else if (fire) begin
                pass_r.valid <= 1'b0;
            end
        end
    end

    // b and bl read the offset view, the rest read the register view
    assign inst_b    = (inst.offs_fmt.opcode == `FE_OP_B);
    assign inst_bl   = (inst.offs_fmt.opcode == `FE_OP_BL);
    assign inst_jirl = (inst.reg_fmt.opcode == `FE_OP_JIRL);
    assign inst_cond = (inst.reg_fmt.opcode >= `FE_OP_BEQ)
                       && (inst.reg_fmt.opcode <= `FE_OP_BGEU);
    assign is_br     = inst_b | inst_bl | inst_jirl | inst_cond;

    assign is_return = inst_jirl && (inst.reg_fmt.imm16 == 16'd0)
                       && (inst.reg_fmt.rj == 5'd1) && (inst.reg_fmt.rd == 5'd0);

    assign bp_error = ~is_br & pass_r.next.is_predict;   // btb hit on a plain word
    assign pc_plus4 = pass_r.pc + 32'd4;
    assign jump_to  = pass_r.pc + {{4{inst.offs_fmt.offs_hi[9]}}, inst.offs_fmt.offs_hi,
                                   inst.offs_fmt.offs_lo, 2'b00};

    always_comb begin
        corr = pass_r.next;
        if (bp_error) begin
            corr.pc         = pc_plus4;
            corr.is_predict = 1'b0;
        end else if (inst_b || inst_bl) begin
            corr.pc         = jump_to;
            corr.is_predict = 1'b0;
        end else if (is_return && ras_top_valid_i) begin
            corr.pc         = ras_top_i;
            corr.is_predict = 1'b1;
        end
    end

    always_comb begin
        dec_o.valid = pass_r.valid & ~rsp_wait & ~flush_i;
        dec_o.pc    = pass_r.pc;
        dec_o.inst  = inst;
        dec_o.next  = corr;
    end

    // fetch1 already followed pass_r.next, so only a different pc needs a restart
    assign fix_o.valid      = fire && (corr.pc != pass_r.next.pc);
    assign fix_o.pc         = corr.pc;
    assign fix_o.is_predict = corr.is_predict;

    assign btb_update_o.valid      = fire & (bp_error | inst_b | inst_bl);
    assign btb_update_o.pc         = pass_r.pc;
    assign btb_update_o.target     = jump_to;
    assign btb_update_o.invalidate = bp_error;

    assign ras_push_o      = fire & inst_bl;
    assign ras_push_addr_o = pc_plus4;
    assign ras_pop_o       = fire & is_return & ras_top_valid_i;

    // fetch1 holds off while a stale response is owed, so nothing can be delivered then
    assert property (@(posedge clk) disable iff (!rst_n) discard_q |-> !dec_o.valid);

endmodule

//--- hw/frontend_top.sv
`timescale 1ns/1ns

module frontend_top (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   icache_req_valid_o,
    output fe_pkg::virt_t          icache_req_addr_o,
    input  logic                   icache_req_ready_i,
    input  fe_pkg::inst_u          icache_rsp_data_i,
    input  logic                   icache_rsp_valid_i,
    output logic                   icache_rsp_ready_o,
    output fe_pkg::fetch2_decode_t dec_o,
    input  logic                   dec_stall_i,
    input  logic                   be_redirect_i,
    input  fe_pkg::virt_t          be_redirect_pc_i
);
    import fe_pkg::*;

    virt_t          lookup_pc;
    logic           btb_hit;
    virt_t          btb_target;
    btb_update_t    btb_update;
    pc_redirect_t   fix;
    fetch1_fetch2_t pass;
    logic           pass_valid;
    logic           f2_busy;
    logic           ras_push;
    virt_t          ras_push_addr;
    logic           ras_pop;
    virt_t          ras_top;
    logic           ras_top_valid;

    fetch_pc_gen fetch_pc_gen_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .be_redirect_i      (be_redirect_i),
        .be_redirect_pc_i   (be_redirect_pc_i),
        .fix_i              (fix),
        .f2_busy_i          (f2_busy),
        .btb_hit_i          (btb_hit),
        .btb_target_i       (btb_target),
        .lookup_pc_o        (lookup_pc),
        .icache_req_valid_o (icache_req_valid_o),
        .icache_req_addr_o  (icache_req_addr_o),
        .icache_req_ready_i (icache_req_ready_i),
        .pass_o             (pass),
        .pass_valid_o       (pass_valid)
    );

    fetch_predecode fetch_predecode_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush_i            (be_redirect_i),
        .dec_stall_i        (dec_stall_i),
        .pass_i             (pass),
        .pass_valid_i       (pass_valid),
        .busy_o             (f2_busy),
        .icache_rsp_data_i  (icache_rsp_data_i),
        .icache_rsp_valid_i (icache_rsp_valid_i),
        .icache_rsp_ready_o (icache_rsp_ready_o),
        .dec_o              (dec_o),
        .fix_o              (fix),
        .btb_update_o       (btb_update),
        .ras_push_o         (ras_push),
        .ras_push_addr_o    (ras_push_addr),
        .ras_pop_o          (ras_pop),
        .ras_top_i          (ras_top),
        .ras_top_valid_i    (ras_top_valid)
    );

    branch_target_buffer branch_target_buffer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_pc_i (lookup_pc),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .update_i    (btb_update)
    );

    return_addr_stack return_addr_stack_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (ras_push),
        .push_addr_i (ras_push_addr),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .top_valid_o (ras_top_valid)
    );

endmodule

//--- hw/return_addr_stack.sv
`timescale 1ns/1ns
`include "fe_consts.svh"

module return_addr_stack (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push_i,
    input  fe_pkg::virt_t push_addr_i,
    input  logic          pop_i,
    output fe_pkg::virt_t top_o,
    output logic          top_valid_o
);
    import fe_pkg::*;

    localparam int PTR_W = $clog2(`FE_RAS_DEPTH);
    localparam int CNT_W = $clog2(`FE_RAS_DEPTH + 1);

    virt_t            stack_q [`FE_RAS_DEPTH];
    logic [PTR_W-1:0] top_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [PTR_W-1:0] push_ptr;

    assign push_ptr    = top_ptr_q + 1'b1;   // wraps onto the oldest entry when full
    assign top_o       = stack_q[top_ptr_q];
    assign top_valid_o = (count_q != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_ptr_q <= '0;
            count_q   <= '0;
        end else if (push_i) begin
            top_ptr_q <= push_ptr;
            if (count_q != CNT_W'(`FE_RAS_DEPTH)) begin
                count_q <= count_q + 1'b1;
            end
        end else if (pop_i) begin
            top_ptr_q <= top_ptr_q - 1'b1;
            count_q   <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[push_ptr] <= push_addr_i;
        end
    end

    // a return retires either as a pop or as nothing, never alongside a call
    assert property (@(posedge clk) disable iff (!rst_n) !(push_i && pop_i));
    assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> top_valid_o);

endmodule
